// File: Makefile
# Verilator flow for the memory sub-group testbench.
# A failing run ends in $fatal, so the sim target returns a non-zero status.

TOP := tb_mempool_sub_group

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f mempool_sub_group.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f mempool_sub_group.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dma_tile_demux.sv
/* Steers DMA requests to one tile by the interleaved tile bits of the address.
   A small order FIFO returns responses in request order. */
`timescale 1ns/10ps
`default_nettype none

module dma_tile_demux #(
  parameter int unsigned RespDepth = 2
) (
  input  wire                clk_i,
  input  wire                rst_n_i,
  // DMA side
  input  wire tcdm_pkg::dma_req_t dma_req_i,
  input  wire                dma_req_valid_i,
  output logic               dma_req_ready_o,
  output tcdm_pkg::dma_rsp_t dma_rsp_o,
  output logic               dma_rsp_valid_o,
  input  wire                dma_rsp_ready_i,
  // Tile side
  output tcdm_pkg::tcdm_req_t [mempool_pkg::NumTiles-1:0] tile_req_o,
  output logic [mempool_pkg::NumTiles-1:0]                tile_req_valid_o,
  input  wire  [mempool_pkg::NumTiles-1:0]                tile_req_ready_i,
  input  wire tcdm_pkg::tcdm_rsp_t [mempool_pkg::NumTiles-1:0] tile_rsp_i,
  input  wire  [mempool_pkg::NumTiles-1:0]                tile_rsp_valid_i,
  output logic [mempool_pkg::NumTiles-1:0]                tile_rsp_ready_o
);

  import mempool_pkg::*;

  localparam int unsigned PtrWidth = (RespDepth > 1) ? $clog2(RespDepth) : 1;
  localparam int unsigned CntWidth = $clog2(RespDepth + 1);

  tile_idx_t             order_q [RespDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   cnt_q;
  tile_idx_t             sel;
  tile_idx_t             head;
  row_t                  row;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;

  assign sel   = dma_req_i.addr[ByteOffset +: TileBits];
  assign row   = dma_req_i.addr[ByteOffset + TileBits +: RowBits];
  assign head  = order_q[rd_ptr_q];
  assign full  = (cnt_q == CntWidth'(RespDepth));
  assign empty = (cnt_q == '0);

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile_ports
    // Payload goes to every tile and valid only to the addressed one
    assign tile_req_o[t].wdata    = dma_req_i.wdata;
    assign tile_req_o[t].wen      = dma_req_i.write;
    assign tile_req_o[t].be       = dma_req_i.strb;
    assign tile_req_o[t].tgt_addr = row;
    assign tile_req_valid_o[t]    = dma_req_valid_i && !full && (sel == tile_idx_t'(t));
    assign tile_rsp_ready_o[t]    = dma_rsp_ready_i && !empty && (head == tile_idx_t'(t));
  end : gen_tile_ports

  assign dma_req_ready_o = !full && tile_req_ready_i[sel];
  assign push            = dma_req_valid_i && dma_req_ready_o;

  assign dma_rsp_o.rdata = tile_rsp_i[head].rdata;
  assign dma_rsp_valid_o = !empty && tile_rsp_valid_i[head];
  assign pop             = dma_rsp_valid_o && dma_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(RespDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(RespDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= sel;
    end
  end

endmodule : dma_tile_demux

`default_nettype wire

// File: mempool_pkg.sv
/* Geometry of the memory sub-group and the plain vector types shared by every block.
   Modules import it inside their body and use scoped names in their port lists. */
`default_nettype none

package mempool_pkg;

  localparam int unsigned NumTiles     = 4;
  localparam int unsigned BankDepth    = 64;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned ByteOffset   = 2;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned TileBits     = $clog2(NumTiles);
  localparam int unsigned RowBits      = $clog2(BankDepth);
  // DMA byte address is row, then tile, then byte (interleaved tiles)
  localparam int unsigned DmaAddrWidth = RowBits + TileBits + ByteOffset;
  // Outstanding DMA responses tracked by the demux
  localparam int unsigned DmaRespDepth = 2;

  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [RowBits-1:0]      row_t;
  typedef logic [TileBits-1:0]     tile_idx_t;
  typedef logic [DmaAddrWidth-1:0] dma_addr_t;

endpackage : mempool_pkg

`default_nettype wire

// File: mempool_sub_group.f
mempool_pkg.sv
tcdm_pkg.sv
spill_register.sv
tcdm_bank.sv
tcdm_bank_arbiter.sv
mempool_tile.sv
dma_tile_demux.sv
mempool_sub_group.sv
tb_mempool_sub_group.sv

// File: mempool_sub_group.sv
/* Top of the memory sub-group: four tiles behind sliced remote ports
   and one shared DMA port routed through the tile demux. */
`timescale 1ns/10ps
`default_nettype none

module mempool_sub_group (
  input  wire                                              clk_i,
  input  wire                                              rst_n_i,
  // Remote port t targets tile t
  input  wire tcdm_pkg::tcdm_req_t [mempool_pkg::NumTiles-1:0] remote_req_i,
  input  wire  [mempool_pkg::NumTiles-1:0]                 remote_req_valid_i,
  output logic [mempool_pkg::NumTiles-1:0]                 remote_req_ready_o,
  output tcdm_pkg::tcdm_rsp_t [mempool_pkg::NumTiles-1:0]  remote_rsp_o,
  output logic [mempool_pkg::NumTiles-1:0]                 remote_rsp_valid_o,
  input  wire  [mempool_pkg::NumTiles-1:0]                 remote_rsp_ready_i,
  // DMA port
  input  wire tcdm_pkg::dma_req_t                          dma_req_i,
  input  wire                                              dma_req_valid_i,
  output logic                                             dma_req_ready_o,
  output tcdm_pkg::dma_rsp_t                               dma_rsp_o,
  output logic                                             dma_rsp_valid_o,
  input  wire                                              dma_rsp_ready_i
);

  import mempool_pkg::*;
  import tcdm_pkg::*;

  // Remote path between the slices and the tiles
  tcdm_req_t [NumTiles-1:0] remote_req;
  logic      [NumTiles-1:0] remote_req_valid;
  logic      [NumTiles-1:0] remote_req_ready;
  tcdm_rsp_t [NumTiles-1:0] remote_rsp;
  logic      [NumTiles-1:0] remote_rsp_valid;
  logic      [NumTiles-1:0] remote_rsp_ready;
  // DMA path between the demux and the tiles
  tcdm_req_t [NumTiles-1:0] dma_tile_req;
  logic      [NumTiles-1:0] dma_tile_req_valid;
  logic      [NumTiles-1:0] dma_tile_req_ready;
  tcdm_rsp_t [NumTiles-1:0] dma_tile_rsp;
  logic      [NumTiles-1:0] dma_tile_rsp_valid;
  logic      [NumTiles-1:0] dma_tile_rsp_ready;

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    spill_register #(
      .T(tcdm_req_t)
    ) u_remote_req_slice (
      .clk_i  (clk_i                ),
      .rst_n_i(rst_n_i              ),
      .data_i (remote_req_i[t]      ),
      .valid_i(remote_req_valid_i[t]),
      .ready_o(remote_req_ready_o[t]),
      .data_o (remote_req[t]        ),
      .valid_o(remote_req_valid[t]  ),
      .ready_i(remote_req_ready[t]  )
    );

    mempool_tile u_tile (
      .clk_i             (clk_i                ),
      .rst_n_i           (rst_n_i              ),
      .remote_req_i      (remote_req[t]        ),
      .remote_req_valid_i(remote_req_valid[t]  ),
      .remote_req_ready_o(remote_req_ready[t]  ),
      .remote_rsp_o      (remote_rsp[t]        ),
      .remote_rsp_valid_o(remote_rsp_valid[t]  ),
      .remote_rsp_ready_i(remote_rsp_ready[t]  ),
      .dma_req_i         (dma_tile_req[t]      ),
      .dma_req_valid_i   (dma_tile_req_valid[t]),
      .dma_req_ready_o   (dma_tile_req_ready[t]),
      .dma_rsp_o         (dma_tile_rsp[t]      ),
      .dma_rsp_valid_o   (dma_tile_rsp_valid[t]),
      .dma_rsp_ready_i   (dma_tile_rsp_ready[t])
    );

    spill_register #(
      .T(tcdm_rsp_t)
    ) u_remote_rsp_slice (
      .clk_i  (clk_i                ),
      .rst_n_i(rst_n_i              ),
      .data_i (remote_rsp[t]        ),
      .valid_i(remote_rsp_valid[t]  ),
      .ready_o(remote_rsp_ready[t]  ),
      .data_o (remote_rsp_o[t]      ),
      .valid_o(remote_rsp_valid_o[t]),
      .ready_i(remote_rsp_ready_i[t])
    );
  end : gen_tiles

  dma_tile_demux #(
    .RespDepth(DmaRespDepth)
  ) u_dma_demux (
    .clk_i           (clk_i             ),
    .rst_n_i         (rst_n_i           ),
    .dma_req_i       (dma_req_i         ),
    .dma_req_valid_i (dma_req_valid_i   ),
    .dma_req_ready_o (dma_req_ready_o   ),
    .dma_rsp_o       (dma_rsp_o         ),
    .dma_rsp_valid_o (dma_rsp_valid_o   ),
    .dma_rsp_ready_i (dma_rsp_ready_i   ),
    .tile_req_o      (dma_tile_req      ),
    .tile_req_valid_o(dma_tile_req_valid),
    .tile_req_ready_i(dma_tile_req_ready),
    .tile_rsp_i      (dma_tile_rsp      ),
    .tile_rsp_valid_i(dma_tile_rsp_valid),
    .tile_rsp_ready_o(dma_tile_rsp_ready)
  );

endmodule : mempool_sub_group

`default_nettype wire

// File: mempool_tile.sv
/* One tile of the sub-group: its bank shared by a remote port and a DMA port.
   Each accepted request gets one response, held on its own port until taken. */
`timescale 1ns/10ps
`default_nettype none

module mempool_tile (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  // Remote port
  input  wire tcdm_pkg::tcdm_req_t remote_req_i,
  input  wire                 remote_req_valid_i,
  output logic                remote_req_ready_o,
  output tcdm_pkg::tcdm_rsp_t remote_rsp_o,
  output logic                remote_rsp_valid_o,
  input  wire                 remote_rsp_ready_i,
  // DMA port
  input  wire tcdm_pkg::tcdm_req_t dma_req_i,
  input  wire                 dma_req_valid_i,
  output logic                dma_req_ready_o,
  output tcdm_pkg::tcdm_rsp_t dma_rsp_o,
  output logic                dma_rsp_valid_o,
  input  wire                 dma_rsp_ready_i
);

  import mempool_pkg::*;
  import tcdm_pkg::*;

  tcdm_req_t bank_req;
  data_t     bank_rdata;
  logic      bank_en;
  logic      rsp_valid_q;
  logic      rsp_dma_q;
  logic      rsp_taken;
  logic      free;

  // Bank may accept when the response slot empties this cycle
  assign rsp_taken = rsp_valid_q && (rsp_dma_q ? dma_rsp_ready_i : remote_rsp_ready_i);
  assign free      = !rsp_valid_q || rsp_taken;

  tcdm_bank_arbiter u_arbiter (
    .clk_i         (clk_i             ),
    .rst_n_i       (rst_n_i           ),
    .remote_valid_i(remote_req_valid_i),
    .dma_valid_i   (dma_req_valid_i   ),
    .free_i        (free              ),
    .remote_gnt_o  (remote_req_ready_o),
    .dma_gnt_o     (dma_req_ready_o   )
  );

  assign bank_en  = remote_req_ready_o || dma_req_ready_o;
  assign bank_req = dma_req_ready_o ? dma_req_i : remote_req_i;

  tcdm_bank u_bank (
    .clk_i  (clk_i     ),
    .rst_n_i(rst_n_i   ),
    .req_i  (bank_req  ),
    .en_i   (bank_en   ),
    .rdata_o(bank_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_dma_q   <= 1'b0;
    end else begin
      rsp_valid_q <= bank_en || (rsp_valid_q && !rsp_taken);
      if (bank_en) begin
        rsp_dma_q <= dma_req_ready_o;
      end
    end
  end

  assign remote_rsp_o.rdata = bank_rdata;
  assign dma_rsp_o.rdata    = bank_rdata;
  assign remote_rsp_valid_o = rsp_valid_q && !rsp_dma_q;
  assign dma_rsp_valid_o    = rsp_valid_q && rsp_dma_q;

endmodule : mempool_tile

`default_nettype wire

// File: spill_register.sv
/* Two-slot valid/ready register slice that cuts the data, valid and ready paths.
   Output valid follows an input transfer by one cycle; full-rate streams pass unstalled. */
`timescale 1ns/10ps
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  T data_i,
  input  wire  valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  wire  ready_i
);

  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Slot a takes new input and leaves when b is empty
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;

  // Slot b catches a's item when the output stalls
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older item sits in b whenever b is full
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule : spill_register

`default_nettype wire

// File: tb_mempool_sub_group.sv
/* Directed testbench for the memory sub-group, checked against a byte-enabled bank model.
   Runs reset, remote, DMA mapping, contention and back-pressure tests in turn. */
`timescale 1ns/10ps
`default_nettype none

module tb_mempool_sub_group;

  import mempool_pkg::*;
  import tcdm_pkg::*;

  localparam int unsigned Timeout = 200;
  localparam int unsigned RandOps = 40;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  tcdm_req_t [NumTiles-1:0] remote_req_i;
  logic      [NumTiles-1:0] remote_req_valid_i;
  logic      [NumTiles-1:0] remote_req_ready_o;
  tcdm_rsp_t [NumTiles-1:0] remote_rsp_o;
  logic      [NumTiles-1:0] remote_rsp_valid_o;
  logic      [NumTiles-1:0] remote_rsp_ready_i;
  dma_req_t                 dma_req_i;
  logic                     dma_req_valid_i;
  logic                     dma_req_ready_o;
  dma_rsp_t                 dma_rsp_o;
  logic                     dma_rsp_valid_o;
  logic                     dma_rsp_ready_i;

  // Reference contents indexed by tile then row
  data_t       model_q [NumTiles][BankDepth];
  int unsigned remote_sent [NumTiles] = '{default: 0};
  int unsigned remote_done [NumTiles] = '{default: 0};
  int unsigned dma_sent = 0;
  int unsigned dma_done = 0;

  always #2 clk_i = ~clk_i;

  mempool_sub_group u_mempool_sub_group (
    .clk_i             (clk_i             ),
    .rst_n_i           (rst_n_i           ),
    .remote_req_i      (remote_req_i      ),
    .remote_req_valid_i(remote_req_valid_i),
    .remote_req_ready_o(remote_req_ready_o),
    .remote_rsp_o      (remote_rsp_o      ),
    .remote_rsp_valid_o(remote_rsp_valid_o),
    .remote_rsp_ready_i(remote_rsp_ready_i),
    .dma_req_i         (dma_req_i         ),
    .dma_req_valid_i   (dma_req_valid_i   ),
    .dma_req_ready_o   (dma_req_ready_o   ),
    .dma_rsp_o         (dma_rsp_o         ),
    .dma_rsp_valid_o   (dma_rsp_valid_o   ),
    .dma_rsp_ready_i   (dma_rsp_ready_i   )
  );

  // Count response handshakes at the outputs to catch lost or extra responses
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int t = 0; t < NumTiles; t++) begin
        if (remote_rsp_valid_o[t] && remote_rsp_ready_i[t]) begin
          remote_done[t]++;
        end
      end
      if (dma_rsp_valid_o && dma_rsp_ready_i) begin
        dma_done++;
      end
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s, got 0x%08h, expected 0x%08h",
                         $time, what, actual, expected));
    end
  endtask

  function automatic void model_write(tile_idx_t tile, row_t row, data_t wdata, strb_t strb);
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        model_q[tile][row][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  endfunction

  function automatic data_t fill_word(int t, int r);
    return {8'hc5, 8'(t), 8'(r), 8'(r ^ (t << 6))};
  endfunction

  // All drive tasks start and end just after a rising edge
  task automatic remote_send(input tile_idx_t t, input logic wen, input strb_t be,
                             input row_t row, input data_t wdata);
    tcdm_req_t   req;
    int unsigned n;
    req.wdata    = wdata;
    req.wen      = wen;
    req.be       = be;
    req.tgt_addr = row;
    n = 0;
    remote_req_i[t]       <= req;
    remote_req_valid_i[t] <= 1'b1;
    @(negedge clk_i);
    while (!remote_req_ready_o[t]) begin
      n++;
      if (n > Timeout) begin
        fail_run($sformatf("Timeout: remote port %0d never accepted its request", t));
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    remote_req_valid_i[t] <= 1'b0;
    remote_sent[t]++;
  endtask

  task automatic wait_remote_rsp(input tile_idx_t t);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!remote_rsp_valid_o[t]) begin
      n++;
      if (n > Timeout) begin
        fail_run($sformatf("Timeout: no response on remote port %0d", t));
      end
      @(negedge clk_i);
    end
  endtask

  task automatic remote_recv(input tile_idx_t t, output data_t rdata);
    wait_remote_rsp(t);
    rdata = remote_rsp_o[t].rdata;
    @(posedge clk_i);
  endtask

  task automatic remote_access(input tile_idx_t t, input logic wen, input strb_t be,
                               input row_t row, input data_t wdata);
    data_t rdata;
    remote_send(t, wen, be, row, wdata);
    remote_recv(t, rdata);
    if (wen) begin
      model_write(t, row, wdata, be);
    end else begin
      check(rdata, model_q[t][row], $sformatf("remote read tile %0d row %0d", t, row));
    end
  endtask

  task automatic dma_send(input tile_idx_t tile, input row_t row, input logic write,
                          input strb_t strb, input data_t wdata);
    dma_req_t    req;
    int unsigned n;
    // Row sits in byte address bits 9..4 and the tile in bits 3..2
    req.addr      = '0;
    req.addr[3:2] = tile;
    req.addr[9:4] = row;
    req.wdata     = wdata;
    req.write     = write;
    req.strb      = strb;
    n = 0;
    dma_req_i       <= req;
    dma_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!dma_req_ready_o) begin
      n++;
      if (n > Timeout) begin
        fail_run("Timeout: the DMA port never accepted its request");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    dma_req_valid_i <= 1'b0;
    dma_sent++;
  endtask

  task automatic wait_dma_rsp();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!dma_rsp_valid_o) begin
      n++;
      if (n > Timeout) begin
        fail_run("Timeout: no response on the DMA port");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic dma_recv(output data_t rdata);
    wait_dma_rsp();
    rdata = dma_rsp_o.rdata;
    @(posedge clk_i);
  endtask

  task automatic dma_access(input tile_idx_t tile, input row_t row, input logic write,
                            input strb_t strb, input data_t wdata);
    data_t rdata;
    dma_send(tile, row, write, strb, wdata);
    dma_recv(rdata);
    if (write) begin
      model_write(tile, row, wdata, strb);
    end else begin
      check(rdata, model_q[tile][row], $sformatf("DMA read tile %0d row %0d", tile, row));
    end
  endtask

  task automatic check_counts();
    int t;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check(data_t'(remote_rsp_valid_o), '0, "remote response valid while idle");
    check(data_t'(dma_rsp_valid_o), '0, "DMA response valid while idle");
    for (t = 0; t < NumTiles; t++) begin
      check(remote_done[t], remote_sent[t], $sformatf("response count on remote port %0d", t));
    end
    check(dma_done, dma_sent, "response count on the DMA port");
    @(posedge clk_i);
  endtask

  task automatic test_reset();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    check(data_t'(remote_rsp_valid_o), '0, "remote response valid after reset");
    check(data_t'(dma_rsp_valid_o), '0, "DMA response valid after reset");
    while (!(&remote_req_ready_o)) begin
      n++;
      if (n > Timeout) begin
        fail_run("Timeout: remote request ready stayed low after reset");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic test_remote();
    int    t;
    int    r;
    int    i;
    row_t  row;
    for (t = 0; t < NumTiles; t++) begin
      for (r = 0; r < BankDepth; r++) begin
        remote_access(tile_idx_t'(t), 1'b1, '1, row_t'(r), fill_word(t, r));
      end
    end
    for (t = 0; t < NumTiles; t++) begin
      for (i = 0; i < 8; i++) begin
        row = row_t'($urandom);
        remote_access(tile_idx_t'(t), 1'b1, strb_t'($urandom), row, $urandom);
        remote_access(tile_idx_t'(t), 1'b0, '0, row, '0);
      end
    end
  endtask

  task automatic test_dma_map();
    int        i;
    tile_idx_t tile;
    row_t      row;
    for (i = 0; i < 16; i++) begin
      tile = tile_idx_t'($urandom);
      row  = row_t'($urandom);
      dma_access(tile, row, 1'b1, strb_t'($urandom), $urandom);
      remote_access(tile, 1'b0, '0, row, '0);
      tile = tile_idx_t'($urandom);
      row  = row_t'($urandom);
      remote_access(tile, 1'b1, strb_t'($urandom), row, $urandom);
      dma_access(tile, row, 1'b0, '0, '0);
    end
  endtask

  // DMA start is skewed so both requests meet at the bank arbiter
  task automatic test_contention();
    int   d;
    int   t;
    row_t row;
    for (d = 0; d < 3; d++) begin
      for (t = 0; t < NumTiles; t++) begin
        row = row_t'($urandom);
        fork
          remote_access(tile_idx_t'(t), 1'b0, '0, row, '0);
          begin
            repeat (d) @(posedge clk_i);
            dma_access(tile_idx_t'(t), row ^ 6'd1, 1'b1, '1, $urandom);
          end
        join
        fork
          remote_access(tile_idx_t'(t), 1'b1, strb_t'($urandom), row, $urandom);
          begin
            repeat (d) @(posedge clk_i);
            dma_access(tile_idx_t'(t), row ^ 6'd1, 1'b0, '0, '0);
          end
        join
        remote_access(tile_idx_t'(t), 1'b0, '0, row, '0);
      end
    end
  endtask

  // Remote port t owns rows 0..31 of tile t and the DMA owns rows 32..63
  task automatic random_remote(input tile_idx_t t);
    int unsigned i;
    for (i = 0; i < RandOps; i++) begin
      repeat ($urandom_range(2, 0)) @(posedge clk_i);
      remote_access(t, 1'($urandom), strb_t'($urandom), row_t'($urandom_range(31, 0)),
                    $urandom);
    end
  endtask

  task automatic random_dma();
    int unsigned i;
    for (i = 0; i < RandOps; i++) begin
      repeat ($urandom_range(2, 0)) @(posedge clk_i);
      dma_access(tile_idx_t'($urandom), row_t'($urandom_range(63, 32)), 1'($urandom),
                 strb_t'($urandom), $urandom);
    end
  endtask

  task automatic test_random();
    fork
      random_remote(2'd0);
      random_remote(2'd1);
      random_remote(2'd2);
      random_remote(2'd3);
      random_dma();
    join
    check_counts();
  endtask

  task automatic test_backpressure();
    int    i;
    data_t rdata;
    remote_access(2'd3, 1'b1, '1, 6'd9, 32'h3333_0909);
    remote_access(2'd1, 1'b1, '1, 6'd9, 32'h1111_0909);
    remote_rsp_ready_i[0] <= 1'b0;
    dma_rsp_ready_i       <= 1'b0;
    remote_send(2'd0, 1'b0, '0, 6'd5, '0);
    // Higher tile goes first so order follows issue and not tile number
    dma_send(2'd3, 6'd9, 1'b0, '0, '0);
    dma_send(2'd1, 6'd9, 1'b0, '0, '0);
    wait_remote_rsp(2'd0);
    wait_dma_rsp();
    for (i = 0; i < 6; i++) begin
      @(negedge clk_i);
      check(data_t'(remote_rsp_valid_o[0]), 1, "held remote response valid");
      check(remote_rsp_o[0].rdata, model_q[0][5], "held remote response data");
      check(data_t'(dma_rsp_valid_o), 1, "held DMA response valid");
      check(dma_rsp_o.rdata, model_q[3][9], "held DMA response data");
    end
    @(posedge clk_i);
    dma_rsp_ready_i <= 1'b1;
    dma_recv(rdata);
    check(rdata, model_q[3][9], "first DMA response in issue order");
    dma_recv(rdata);
    check(rdata, model_q[1][9], "second DMA response in issue order");
    remote_rsp_ready_i[0] <= 1'b1;
    remote_recv(2'd0, rdata);
    check(rdata, model_q[0][5], "released remote response");
    check_counts();
  endtask

  initial begin
    void'($urandom(63332));
    rst_n_i            <= 1'b0;
    remote_req_i       <= '0;
    remote_req_valid_i <= '0;
    remote_rsp_ready_i <= '1;
    dma_req_i          <= '0;
    dma_req_valid_i    <= 1'b0;
    dma_rsp_ready_i    <= 1'b1;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_remote();
    test_dma_map();
    test_contention();
    test_random();
    test_backpressure();
    $display("TB PASSED");
    $finish;
  end

endmodule : tb_mempool_sub_group

`default_nettype wire

// File: tcdm_bank.sv
/* Single-port word memory of one tile with byte-enabled writes.
   Read data appears one cycle after an enabled read access. */
`timescale 1ns/10ps
`default_nettype none

module tcdm_bank (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire tcdm_pkg::tcdm_req_t req_i,
  input  wire                 en_i,
  output mempool_pkg::data_t  rdata_o
);

  import mempool_pkg::*;

  data_t mem_q [BankDepth];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i && req_i.wen) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.tgt_addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Last read word is held until the next read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (en_i && !req_i.wen) begin
      rdata_q <= mem_q[req_i.tgt_addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule : tcdm_bank

`default_nettype wire

// File: tcdm_bank_arbiter.sv
/* Two-way round-robin arbiter between the remote and DMA requests of one tile.
   Grants are combinational and only issued while the bank can take a request. */
`timescale 1ns/10ps
`default_nettype none

module tcdm_bank_arbiter (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  remote_valid_i,
  input  wire  dma_valid_i,
  input  wire  free_i,
  output logic remote_gnt_o,
  output logic dma_gnt_o
);

  // High when the DMA won the last contended grant
  logic dma_last_q;
  logic contended;

  assign contended = remote_valid_i && dma_valid_i;

  always_comb begin
    remote_gnt_o = 1'b0;
    dma_gnt_o    = 1'b0;
    if (free_i) begin
      if (contended) begin
        remote_gnt_o = dma_last_q;
        dma_gnt_o    = !dma_last_q;
      end else begin
        remote_gnt_o = remote_valid_i;
        dma_gnt_o    = dma_valid_i;
      end
    end
  end

  // Flip priority after each contended grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dma_last_q <= 1'b1;
    end else if (free_i && contended) begin
      dma_last_q <= !dma_last_q;
    end
  end

endmodule : tcdm_bank_arbiter

`default_nettype wire

// File: tcdm_pkg.sv
/* Request and response payloads of the remote TCDM ports and of the DMA port.
   Valid and ready travel beside these structs, never inside them. */
`default_nettype none

package tcdm_pkg;

  import mempool_pkg::*;

  // Remote port and bank request
  typedef struct packed {
    data_t wdata;
    logic  wen;
    strb_t be;
    row_t  tgt_addr;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_rsp_t;

  // DMA request carries a full byte address
  typedef struct packed {
    dma_addr_t addr;
    data_t     wdata;
    logic      write;
    strb_t     strb;
  } dma_req_t;

  typedef struct packed {
    data_t rdata;
  } dma_rsp_t;

endpackage : tcdm_pkg

`default_nettype wire
